//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the simulator exit code is ignored
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Verification failed" $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                          w_Selector2_fire_2,
    input  logic                          rstn,
    // lsu side
    input  logic                          i_lsu_drive,
    input  logic                          i_lsu_load,
    input  logic [dcache_pkg::PA_W-1:0]   i_lsu_pa,
    input  logic [3:0]                    i_store_type,
    input  logic [dcache_pkg::WORD_W-1:0] i_store_data,
    input  logic [5:0]                    i_store_index,
    output logic                          o_lsu_free,
    output logic                          o_retire_load_drive,
    output logic [dcache_pkg::WORD_W-1:0] o_load_data,
    output logic                          o_store_done,
    output logic [5:0]                    o_store_index,
    // l2 side
    output logic                          o_l2_miss_drive,
    output logic [dcache_pkg::PA_W-1:0]   o_miss_addr,
    input  logic                          i_l2_refill_drive,
    input  logic [dcache_pkg::LINE_W-1:0] i_refill_line,
    output logic                          o_l2_wb_drive,
    output logic [dcache_pkg::PA_W-1:0]   o_wb_addr,
    output logic [dcache_pkg::LINE_W-1:0] o_wb_line,
    input  logic                          i_l2_wb_free,
    // to the arrays
    output logic [dcache_pkg::IDX_W-1:0]  o_index,
    output logic [dcache_pkg::TAG_W-1:0]  o_tag,
    output logic                          o_tag_we,
    output logic                          o_set_dirty,
    output logic                          o_data_we_word,
    output logic                          o_data_we_line,
    output logic [2:0]                    o_word_sel,
    output logic [3:0]                    o_byte_en,
    output logic [dcache_pkg::WAY_W-1:0]  o_way,
    output logic [dcache_pkg::WORD_W-1:0] o_word,
    output logic                          o_plru_touch,
    // from the arrays
    input  logic                          i_hit,
    input  logic [dcache_pkg::WAY_W-1:0]  i_hit_way,
    input  logic [dcache_pkg::WAY_W-1:0]  i_victim_way,
    input  logic                          i_victim_dirty,
    input  logic [dcache_pkg::TAG_W-1:0]  i_victim_tag,
    input  logic [dcache_pkg::LINE_W-1:0] i_line
);
    import dcache_pkg::*;

    dcache_state_e     state;
    logic [PA_W-1:0]   r_pa;
    logic              r_load;
    logic [3:0]        r_byte_en;
    logic [WORD_W-1:0] r_data;
    logic [5:0]        r_store_index;
    logic [WAY_W-1:0]  r_way;           // victim way, fixed after lookup
    dcache_line_u      line_view;
    dcache_line_u      refill_view;
    logic              lookup_hit;
    logic              refill_take;

    assign line_view   = i_line;
    assign refill_view = i_refill_line;
    assign lookup_hit  = (state == st_lookup) && i_hit;
    assign refill_take = (state == st_miss_wait) && i_l2_refill_drive;

    //////////////////////////////////////////////////////////////////////
    // request and payload registers

    always_ff @(posedge w_Selector2_fire_2) begin
        if (state == st_idle && i_lsu_drive) begin
            r_pa          <= i_lsu_pa;
            r_load        <= i_lsu_load;
            r_byte_en     <= i_store_type;
            r_data        <= i_store_data;
            r_store_index <= i_store_index;
        end
        if (lookup_hit) begin
            o_load_data <= line_view.words[o_word_sel];
        end else if (refill_take) begin
            o_load_data <= refill_view.words[o_word_sel];  // load miss word
        end
        if (state == st_lookup && !i_hit && i_victim_dirty) begin
            o_wb_line <= i_line;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state sequence

    always_ff @(posedge w_Selector2_fire_2 or negedge rstn) begin
        if (!rstn) begin
            state           <= st_idle;
            r_way           <= '0;
            o_l2_wb_drive   <= 1'b0;
            o_l2_miss_drive <= 1'b0;
            o_wb_addr       <= '0;
            o_miss_addr     <= '0;
        end else begin
            o_l2_wb_drive   <= 1'b0;
            o_l2_miss_drive <= 1'b0;
            case (state)
                st_idle: begin
                    if (i_lsu_drive) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    r_way       <= i_victim_way;
                    o_miss_addr <= {o_tag, o_index, {OFS_W{1'b0}}};
                    if (i_hit) begin
                        state <= st_respond;
                    end else if (i_victim_dirty) begin
                        state         <= st_write_back;
                        o_l2_wb_drive <= 1'b1;
                        o_wb_addr     <= {i_victim_tag, o_index, {OFS_W{1'b0}}};
                    end else begin
                        state           <= st_miss_wait;
                        o_l2_miss_drive <= 1'b1;
                    end
                end
                st_write_back: begin
                    if (i_l2_wb_free) begin     // miss goes out only after the wb
                        state           <= st_miss_wait;
                        o_l2_miss_drive <= 1'b1;
                    end
                end
                st_miss_wait: begin
                    if (i_l2_refill_drive) begin
                        state <= st_fill;
                    end
                end
                st_fill:    state <= st_respond;
                default:    state <= st_idle;    // respond lasts one cycle
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // array controls and lsu strobes

    assign o_index    = r_pa[OFS_W +: IDX_W];
    assign o_tag      = r_pa[PA_W-1 -: TAG_W];
    assign o_word_sel = r_pa[OFS_W-1:2];
    assign o_byte_en  = r_byte_en;
    assign o_word     = r_data;

    // hit way on a hit, victim while deciding a miss, latched victim after
    assign o_way = (state == st_lookup) ? (i_hit ? i_hit_way : i_victim_way) : r_way;

    assign o_tag_we       = refill_take;                 // full line plus valid
    assign o_data_we_line = refill_take;
    assign o_data_we_word = (lookup_hit || refill_take) && !r_load;  // store merge
    assign o_set_dirty    = o_data_we_word;
    assign o_plru_touch   = lookup_hit || (state == st_fill);

    assign o_lsu_free          = (state == st_respond);
    assign o_retire_load_drive = o_lsu_free && r_load;
    assign o_store_done        = o_lsu_free && !r_load;
    assign o_store_index       = r_store_index;

endmodule

//--- hw/dcache_data_array.sv
`timescale 1ns/1ns

module dcache_data_array (
    input  logic                          w_Selector2_fire_2,
    input  logic [dcache_pkg::IDX_W-1:0]  i_index,
    input  logic [dcache_pkg::WAY_W-1:0]  i_way,
    input  logic                          i_we_line,
    input  logic [dcache_pkg::LINE_W-1:0] i_line,
    input  logic                          i_we_word,
    input  logic [2:0]                    i_word_sel,
    input  logic [3:0]                    i_byte_en,
    input  logic [dcache_pkg::WORD_W-1:0] i_word,
    output logic [dcache_pkg::LINE_W-1:0] o_line
);
    import dcache_pkg::*;

    dcache_line_u mem [NUM_SETS][NUM_WAYS];
    dcache_line_u wr_line;

    assign o_line = mem[i_index][i_way];    // async read of the addressed way

    // refill line first, then the store bytes on top of it
    always_comb begin
        wr_line = i_we_line ? dcache_line_u'(i_line) : mem[i_index][i_way];
        for (int b = 0; b < 4; b++) begin
            if (i_we_word && i_byte_en[b]) begin
                wr_line.bytes[{i_word_sel, 2'(b)}] = i_word[8*b +: 8];
            end
        end
    end

    always_ff @(posedge w_Selector2_fire_2) begin
        if (i_we_line || i_we_word) begin
            mem[i_index][i_way] <= wr_line;
        end
    end

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

    //////////////////////////////////////////////////////////////////////
    // geometry

    localparam int PA_W           = 34;
    localparam int TAG_W          = 24;     // pa[33:10]
    localparam int IDX_W          = 5;      // pa[9:5]
    localparam int OFS_W          = 5;      // byte within line
    localparam int NUM_WAYS       = 8;
    localparam int WAY_W          = 3;
    localparam int NUM_SETS       = 32;
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 256;
    localparam int WORDS_PER_LINE = 8;
    localparam int PLRU_W         = 7;      // one bit per tree node

    //////////////////////////////////////////////////////////////////////
    // types

    // one cache line, word view or byte view
    typedef union packed {
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;  // load select, store merge
        logic [LINE_W/8-1:0][7:0]              bytes;  // byte enables
    } dcache_line_u;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,  // waiting for l2 to take the victim
        st_miss_wait,   // waiting for the refill line
        st_fill,
        st_respond
    } dcache_state_e;

endpackage

//--- hw/dcache_plru.sv
`timescale 1ns/1ns

module dcache_plru (
    input  logic                            w_Selector2_fire_2,
    input  logic                            rstn,
    input  logic [dcache_pkg::IDX_W-1:0]    i_index,
    input  logic                            i_touch,
    input  logic [dcache_pkg::WAY_W-1:0]    i_way,
    input  logic [dcache_pkg::NUM_WAYS-1:0] i_way_valid,
    output logic [dcache_pkg::WAY_W-1:0]    o_victim_way
);
    import dcache_pkg::*;

    // bit 0 root, bits 1..2 the halves, bits 3..6 the pairs
    // a bit of 0 points at the lower half as less recently used
    logic [PLRU_W-1:0] tree [NUM_SETS];
    logic [PLRU_W-1:0] cur;
    logic              b_root;
    logic              b_half;
    logic              b_pair;
    logic [WAY_W-1:0]  free_way;

    assign cur    = tree[i_index];
    assign b_root = cur[0];
    assign b_half = cur[1 + b_root];
    assign b_pair = cur[3 + {b_root, b_half}];

    // lowest numbered invalid way
    always_comb begin
        free_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!i_way_valid[w]) begin
                free_way = WAY_W'(w);
            end
        end
    end

    assign o_victim_way = (&i_way_valid) ? {b_root, b_half, b_pair} : free_way;

    // point every node on the path away from the touched way
    always_ff @(posedge w_Selector2_fire_2 or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (i_touch) begin
            tree[i_index][0]                <= ~i_way[2];
            tree[i_index][1 + i_way[2]]     <= ~i_way[1];
            tree[i_index][3 + i_way[2:1]]   <= ~i_way[0];
        end
    end

endmodule

//--- hw/dcache_tag_array.sv
`timescale 1ns/1ns

module dcache_tag_array (
    input  logic                            w_Selector2_fire_2,
    input  logic                            rstn,
    input  logic [dcache_pkg::IDX_W-1:0]    i_index,
    input  logic [dcache_pkg::TAG_W-1:0]    i_tag,
    input  logic                            i_tag_we,
    input  logic                            i_set_dirty,
    input  logic [dcache_pkg::WAY_W-1:0]    i_way,
    input  logic [dcache_pkg::WAY_W-1:0]    i_victim_way,
    output logic                            o_hit,
    output logic [dcache_pkg::WAY_W-1:0]    o_hit_way,
    output logic [dcache_pkg::NUM_WAYS-1:0] o_way_valid,
    output logic                            o_victim_dirty,
    output logic [dcache_pkg::TAG_W-1:0]    o_victim_tag
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]    tags  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty [NUM_SETS];
    logic [NUM_WAYS-1:0] match;

    always_ff @(posedge w_Selector2_fire_2) begin
        if (i_tag_we) begin
            tags[i_index][i_way] <= i_tag;
        end
    end

    // a refill makes the line valid and clean unless the store lands with it
    always_ff @(posedge w_Selector2_fire_2 or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else if (i_tag_we) begin
            valid[i_index][i_way] <= 1'b1;
            dirty[i_index][i_way] <= i_set_dirty;
        end else if (i_set_dirty) begin
            dirty[i_index][i_way] <= 1'b1;
        end
    end

    // all eight ways compared at once
    always_comb begin
        o_hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = valid[i_index][w] && (tags[i_index][w] == i_tag);
            if (match[w]) begin
                o_hit_way = WAY_W'(w);
            end
        end
    end

    assign o_hit          = |match;
    assign o_way_valid    = valid[i_index];
    assign o_victim_dirty = valid[i_index][i_victim_way] && dirty[i_index][i_victim_way];
    assign o_victim_tag   = tags[i_index][i_victim_way];

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic                          w_Selector2_fire_2,
    input  logic                          rstn,
    input  logic                          i_lsu_drive,
    input  logic                          i_lsu_load,
    input  logic [dcache_pkg::PA_W-1:0]   i_lsu_pa,
    input  logic [3:0]                    i_store_type,
    input  logic [dcache_pkg::WORD_W-1:0] i_store_data,
    input  logic [5:0]                    i_store_index,
    output logic                          o_lsu_free,
    output logic                          o_retire_load_drive,
    output logic [dcache_pkg::WORD_W-1:0] o_load_data,
    output logic                          o_store_done,
    output logic [5:0]                    o_store_index,
    output logic                          o_l2_miss_drive,
    output logic [dcache_pkg::PA_W-1:0]   o_miss_addr,
    input  logic                          i_l2_refill_drive,
    input  logic [dcache_pkg::LINE_W-1:0] i_refill_line,
    output logic                          o_l2_wb_drive,
    output logic [dcache_pkg::PA_W-1:0]   o_wb_addr,
    output logic [dcache_pkg::LINE_W-1:0] o_wb_line,
    input  logic                          i_l2_wb_free
);
    import dcache_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // controller to arrays
    logic [IDX_W-1:0]    index;
    logic [TAG_W-1:0]    tag;
    logic                tag_we;
    logic                set_dirty;
    logic                data_we_word;
    logic                data_we_line;
    logic [2:0]          word_sel;
    logic [3:0]          byte_en;
    logic [WAY_W-1:0]    way;
    logic [WORD_W-1:0]   word;
    logic                plru_touch;
    // arrays to controller
    logic                hit;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    victim_way;
    logic                victim_dirty;
    logic [TAG_W-1:0]    victim_tag;
    logic [LINE_W-1:0]   line;
    logic [NUM_WAYS-1:0] way_valid;    // tag array to plru

    dcache_ctrl u_ctrl (
        .w_Selector2_fire_2  (w_Selector2_fire_2),
        .rstn                (rstn),
        .i_lsu_drive         (i_lsu_drive),
        .i_lsu_load          (i_lsu_load),
        .i_lsu_pa            (i_lsu_pa),
        .i_store_type        (i_store_type),
        .i_store_data        (i_store_data),
        .i_store_index       (i_store_index),
        .o_lsu_free          (o_lsu_free),
        .o_retire_load_drive (o_retire_load_drive),
        .o_load_data         (o_load_data),
        .o_store_done        (o_store_done),
        .o_store_index       (o_store_index),
        .o_l2_miss_drive     (o_l2_miss_drive),
        .o_miss_addr         (o_miss_addr),
        .i_l2_refill_drive   (i_l2_refill_drive),
        .i_refill_line       (i_refill_line),
        .o_l2_wb_drive       (o_l2_wb_drive),
        .o_wb_addr           (o_wb_addr),
        .o_wb_line           (o_wb_line),
        .i_l2_wb_free        (i_l2_wb_free),
        .o_index             (index),
        .o_tag               (tag),
        .o_tag_we            (tag_we),
        .o_set_dirty         (set_dirty),
        .o_data_we_word      (data_we_word),
        .o_data_we_line      (data_we_line),
        .o_word_sel          (word_sel),
        .o_byte_en           (byte_en),
        .o_way               (way),
        .o_word              (word),
        .o_plru_touch        (plru_touch),
        .i_hit               (hit),
        .i_hit_way           (hit_way),
        .i_victim_way        (victim_way),
        .i_victim_dirty      (victim_dirty),
        .i_victim_tag        (victim_tag),
        .i_line              (line)
    );

    dcache_tag_array u_tag_array (
        .w_Selector2_fire_2 (w_Selector2_fire_2),
        .rstn               (rstn),
        .i_index            (index),
        .i_tag              (tag),
        .i_tag_we           (tag_we),
        .i_set_dirty        (set_dirty),
        .i_way              (way),
        .i_victim_way       (victim_way),
        .o_hit              (hit),
        .o_hit_way          (hit_way),
        .o_way_valid        (way_valid),
        .o_victim_dirty     (victim_dirty),
        .o_victim_tag       (victim_tag)
    );

    // refill line goes straight in, written on the refill strobe
    dcache_data_array u_data_array (
        .w_Selector2_fire_2 (w_Selector2_fire_2),
        .i_index            (index),
        .i_way              (way),
        .i_we_line          (data_we_line),
        .i_line             (i_refill_line),
        .i_we_word          (data_we_word),
        .i_word_sel         (word_sel),
        .i_byte_en          (byte_en),
        .i_word             (word),
        .o_line             (line)
    );

    dcache_plru u_plru (
        .w_Selector2_fire_2 (w_Selector2_fire_2),
        .rstn               (rstn),
        .i_index            (index),
        .i_touch            (plru_touch),
        .i_way              (way),
        .i_way_valid        (way_valid),
        .o_victim_way       (victim_way)
    );

endmodule

//--- tests/dcache_assert.sv
`timescale 1ns/1ns

module dcache_assert (
    input logic                          w_Selector2_fire_2,
    input logic                          rstn,
    input dcache_pkg::dcache_state_e     i_state,
    input logic                          i_lsu_drive,
    input logic                          i_lsu_load,
    input logic [dcache_pkg::PA_W-1:0]   i_lsu_pa,
    input logic                          i_lsu_free,
    input logic                          i_retire_load_drive,
    input logic                          i_store_done,
    input logic                          i_wb_drive,
    input logic [dcache_pkg::PA_W-1:0]   i_wb_addr,
    input logic                          i_miss_drive,
    input logic [dcache_pkg::PA_W-1:0]   i_miss_addr
);
    import dcache_pkg::*;

    logic            open_load;     // kind of the request in flight
    logic [PA_W-1:0] open_pa;

    always_ff @(posedge w_Selector2_fire_2 or negedge rstn) begin
        if (!rstn) begin
            open_load <= 1'b0;
            open_pa   <= '0;
        end else if (i_lsu_drive) begin
            open_load <= i_lsu_load;
            open_pa   <= i_lsu_pa;
        end
    end

    // one request in flight
    a_single_request: assert property (@(posedge w_Selector2_fire_2) disable iff (!rstn)
        i_lsu_drive |-> (i_state == st_idle))
        else $error("lsu drive while a request is open");

    // response strobe follows the kind of request that was driven
    a_free_kind: assert property (@(posedge w_Selector2_fire_2) disable iff (!rstn)
        i_lsu_free |-> (i_retire_load_drive == open_load) && (i_store_done == !open_load))
        else $error("lsu free without the response strobe of the open request");

    // address held from the strobe until the l2 frees it
    a_wb_addr_hold: assert property (@(posedge w_Selector2_fire_2) disable iff (!rstn)
        (i_state == st_write_back && !i_wb_drive) |-> $stable(i_wb_addr))
        else $error("write-back address moved before the l2 took it");

    // aligned line of the open request
    a_miss_aligned: assert property (@(posedge w_Selector2_fire_2) disable iff (!rstn)
        i_miss_drive |-> (i_miss_addr == {open_pa[PA_W-1:OFS_W], OFS_W'(0)}))
        else $error("miss address is not the aligned line of the request");

endmodule

bind dcache_top dcache_assert u_assert (
    .w_Selector2_fire_2  (w_Selector2_fire_2),
    .rstn                (rstn),
    .i_state             (u_ctrl.state),
    .i_lsu_drive         (i_lsu_drive),
    .i_lsu_load          (i_lsu_load),
    .i_lsu_pa            (i_lsu_pa),
    .i_lsu_free          (o_lsu_free),
    .i_retire_load_drive (o_retire_load_drive),
    .i_store_done        (o_store_done),
    .i_wb_drive          (o_l2_wb_drive),
    .i_wb_addr           (o_wb_addr),
    .i_miss_drive        (o_l2_miss_drive),
    .i_miss_addr         (o_miss_addr)
);

//--- tests/tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache;
    import dcache_pkg::*;

    localparam int          WAIT_MAX  = 200;            // cycles per wait
    localparam logic [31:0] WORD_BASE = 32'h0bad_0000;  // unwritten l2 words

    logic                w_Selector2_fire_2;
    logic                rstn;
    logic                i_lsu_drive;
    logic                i_lsu_load;
    logic [PA_W-1:0]     i_lsu_pa;
    logic [3:0]          i_store_type;
    logic [WORD_W-1:0]   i_store_data;
    logic [5:0]          i_store_index;
    logic                o_lsu_free;
    logic                o_retire_load_drive;
    logic [WORD_W-1:0]   o_load_data;
    logic                o_store_done;
    logic [5:0]          o_store_index;
    logic                o_l2_miss_drive;
    logic [PA_W-1:0]     o_miss_addr;
    logic                i_l2_refill_drive;
    logic [LINE_W-1:0]   i_refill_line;
    logic                o_l2_wb_drive;
    logic [PA_W-1:0]     o_wb_addr;
    logic [LINE_W-1:0]   o_wb_line;
    logic                i_l2_wb_free;

    logic [LINE_W-1:0]   l2_mem  [logic [28:0]];    // l2 lines by line address
    logic [WORD_W-1:0]   ref_mem [logic [31:0]];    // every store, by word address
    int                  miss_count = 0;
    int                  wb_count = 0;
    int                  last_cycles;
    logic [PA_W-1:0]     last_miss_addr;
    logic [PA_W-1:0]     last_wb_addr;
    logic [LINE_W-1:0]   last_wb_line;

    dcache_top uut (
        .w_Selector2_fire_2  (w_Selector2_fire_2),
        .rstn                (rstn),
        .i_lsu_drive         (i_lsu_drive),
        .i_lsu_load          (i_lsu_load),
        .i_lsu_pa            (i_lsu_pa),
        .i_store_type        (i_store_type),
        .i_store_data        (i_store_data),
        .i_store_index       (i_store_index),
        .o_lsu_free          (o_lsu_free),
        .o_retire_load_drive (o_retire_load_drive),
        .o_load_data         (o_load_data),
        .o_store_done        (o_store_done),
        .o_store_index       (o_store_index),
        .o_l2_miss_drive     (o_l2_miss_drive),
        .o_miss_addr         (o_miss_addr),
        .i_l2_refill_drive   (i_l2_refill_drive),
        .i_refill_line       (i_refill_line),
        .o_l2_wb_drive       (o_l2_wb_drive),
        .o_wb_addr           (o_wb_addr),
        .o_wb_line           (o_wb_line),
        .i_l2_wb_free        (i_l2_wb_free)
    );

    initial begin
        w_Selector2_fire_2 = 1'b0;
        forever #4 w_Selector2_fire_2 = ~w_Selector2_fire_2;
    end

    //////////////////////////////////////////////////////////////////////
    // expected values and checking

    function automatic logic [PA_W-1:0] pa_of(input logic [TAG_W-1:0] tag,
                                              input logic [IDX_W-1:0] idx,
                                              input logic [2:0] word);
        return {tag, idx, word, 2'b00};
    endfunction

    // l2 contents, a line never written back follows its word addresses
    function automatic logic [LINE_W-1:0] model_line(input logic [28:0] la);
        logic [LINE_W-1:0] line;
        if (l2_mem.exists(la)) begin
            return l2_mem[la];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[32*w +: 32] = {la, 3'(w)} + WORD_BASE;
        end
        return line;
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input logic [31:0] wa);
        if (ref_mem.exists(wa)) begin
            return ref_mem[wa];
        end
        return wa + WORD_BASE;
    endfunction

    function automatic logic [WORD_W-1:0] byte_merge(input logic [WORD_W-1:0] old,
                                                     input logic [WORD_W-1:0] data,
                                                     input logic [3:0] be);
        logic [WORD_W-1:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [LINE_W-1:0] got,
                           input logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // l2 model, answers one strobe at a time

    task automatic accept_write_back();
        int delay;
        delay = $urandom_range(5, 1);
        wb_count++;
        last_wb_addr = o_wb_addr;
        last_wb_line = o_wb_line;
        l2_mem[o_wb_addr[PA_W-1:OFS_W]] = o_wb_line;
        repeat (delay) begin
            @(posedge w_Selector2_fire_2);
            #1;
        end
        i_l2_wb_free = 1'b1;
        @(posedge w_Selector2_fire_2);
        #1;
        i_l2_wb_free = 1'b0;    // miss strobe may already be up here
    endtask

    task automatic serve_miss();
        int                delay;
        logic [LINE_W-1:0] line;
        delay = $urandom_range(5, 1);
        miss_count++;
        last_miss_addr = o_miss_addr;
        line = model_line(o_miss_addr[PA_W-1:OFS_W]);
        repeat (delay) begin
            @(posedge w_Selector2_fire_2);
            #1;
        end
        i_refill_line     = line;
        i_l2_refill_drive = 1'b1;
        @(posedge w_Selector2_fire_2);
        #1;
        i_l2_refill_drive = 1'b0;
    endtask

    initial begin
        i_l2_refill_drive = 1'b0;
        i_refill_line     = '0;
        i_l2_wb_free      = 1'b0;
        forever begin
            if (o_l2_wb_drive === 1'b1) begin
                accept_write_back();
            end else if (o_l2_miss_drive === 1'b1) begin
                serve_miss();
            end else begin
                @(posedge w_Selector2_fire_2);
                #1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lsu requests and directed tests

    // one request, checked against the reference memory on completion
    task automatic lsu_access(input logic load, input logic [PA_W-1:0] pa,
                              input logic [3:0] be, input logic [WORD_W-1:0] data,
                              input logic [5:0] sidx);
        int n;
        @(posedge w_Selector2_fire_2);
        #1;
        i_lsu_drive   = 1'b1;
        i_lsu_load    = load;
        i_lsu_pa      = pa;
        i_store_type  = be;
        i_store_data  = data;
        i_store_index = sidx;
        n = 0;
        do begin
            @(posedge w_Selector2_fire_2);
            #1;
            i_lsu_drive = 1'b0;
            n++;
            if (n > WAIT_MAX) begin
                stop_with_error("timeout, the cache never freed the lsu");
            end
        end while (o_lsu_free !== 1'b1);
        last_cycles = n;
        compare("o_retire_load_drive", LINE_W'(o_retire_load_drive), LINE_W'(load));
        compare("o_store_done", LINE_W'(o_store_done), LINE_W'(!load));
        if (load) begin
            compare("o_load_data", LINE_W'(o_load_data),
                    LINE_W'(expected_word(pa[PA_W-1:2])));
        end else begin
            compare("o_store_index", LINE_W'(o_store_index), LINE_W'(sidx));
            ref_mem[pa[PA_W-1:2]] = byte_merge(expected_word(pa[PA_W-1:2]), data, be);
        end
    endtask

    task automatic reset_idle();
        repeat (4) begin
            @(posedge w_Selector2_fire_2);
            #1;
            compare("idle strobes", LINE_W'({o_lsu_free, o_retire_load_drive, o_store_done,
                    o_l2_miss_drive, o_l2_wb_drive}), LINE_W'(0));
        end
    endtask

    task automatic load_miss_then_hit();
        logic [PA_W-1:0] pa;
        int              m0;
        pa = pa_of(24'h000123, 5'd3, 3'd5);
        m0 = miss_count;
        lsu_access(1'b1, pa, 4'h0, 32'h0, 6'h0);
        compare("miss requests", LINE_W'(miss_count - m0), LINE_W'(1));
        compare("o_miss_addr", LINE_W'(last_miss_addr), LINE_W'({pa[PA_W-1:OFS_W], 5'b0}));
        lsu_access(1'b1, pa, 4'h0, 32'h0, 6'h0);    // now a hit
        compare("miss requests", LINE_W'(miss_count - m0), LINE_W'(1));
        compare("hit latency", LINE_W'(last_cycles), LINE_W'(2));
    endtask

    task automatic store_bytes();
        logic [PA_W-1:0] pa;
        int              m0;
        pa = pa_of(24'h000123, 5'd3, 3'd2);
        m0 = miss_count;
        lsu_access(1'b0, pa, 4'b0101, 32'hdead_beef, 6'h2a);
        compare("hit latency", LINE_W'(last_cycles), LINE_W'(2));
        lsu_access(1'b1, pa, 4'h0, 32'h0, 6'h0);
        compare("miss requests", LINE_W'(miss_count - m0), LINE_W'(0));
        pa = pa_of(24'h000456, 5'd7, 3'd6);         // store allocate
        lsu_access(1'b0, pa, 4'b1000, 32'h1357_9bdf, 6'h15);
        compare("miss requests", LINE_W'(miss_count - m0), LINE_W'(1));
        lsu_access(1'b1, pa, 4'h0, 32'h0, 6'h0);
    endtask

    task automatic plru_eviction();
        int m0;
        int wb0;
        wb0 = wb_count;
        for (int i = 0; i <= 8; i++) begin
            lsu_access(1'b1, pa_of(24'h000100 + 24'(i), 5'd12, 3'(i)), 4'h0, 32'h0, 6'h0);
        end
        m0 = miss_count;
        for (int i = 1; i <= 8; i++) begin
            lsu_access(1'b1, pa_of(24'h000100 + 24'(i), 5'd12, 3'd0), 4'h0, 32'h0, 6'h0);
        end
        compare("miss requests", LINE_W'(miss_count - m0), LINE_W'(0));
        lsu_access(1'b1, pa_of(24'h000100, 5'd12, 3'd0), 4'h0, 32'h0, 6'h0);
        compare("miss requests", LINE_W'(miss_count - m0), LINE_W'(1));
        compare("write-backs", LINE_W'(wb_count - wb0), LINE_W'(0));   // all clean
    endtask

    task automatic dirty_write_back();
        logic [PA_W-1:0]   pa;
        logic [LINE_W-1:0] exp_line;
        int                wb0;
        int                m0;
        pa = pa_of(24'h000200, 5'd20, 3'd1);
        lsu_access(1'b0, pa, 4'b1111, 32'hcafe_f00d, 6'h11);
        wb0 = wb_count;
        for (int i = 1; i <= 8; i++) begin
            lsu_access(1'b1, pa_of(24'h000200 + 24'(i), 5'd20, 3'd0), 4'h0, 32'h0, 6'h0);
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            exp_line[32*w +: 32] = expected_word({pa[PA_W-1:OFS_W], 3'(w)});
        end
        compare("write-backs", LINE_W'(wb_count - wb0), LINE_W'(1));
        compare("o_wb_addr", LINE_W'(last_wb_addr), LINE_W'({pa[PA_W-1:OFS_W], 5'b0}));
        compare("o_wb_line", last_wb_line, exp_line);
        m0 = miss_count;
        lsu_access(1'b1, pa, 4'h0, 32'h0, 6'h0);   // back from the l2 model
        compare("miss requests", LINE_W'(miss_count - m0), LINE_W'(1));
    endtask

    // three sets that already hold lines, so dirty evictions happen too
    task automatic random_mix();
        logic [IDX_W-1:0] sets [3];
        logic [PA_W-1:0]  pa;
        sets[0] = 5'd3;
        sets[1] = 5'd12;
        sets[2] = 5'd20;
        for (int i = 0; i < 200; i++) begin
            pa = pa_of(24'h000500 + 24'($urandom_range(7, 0)), sets[$urandom_range(2, 0)],
                       3'($urandom_range(7, 0)));
            lsu_access(1'($urandom_range(1, 0)), pa, 4'($urandom_range(15, 0)), $urandom,
                       6'(i));
        end
    endtask

    initial begin
        void'($urandom(32'hdb4f_8ddd));
        rstn          = 1'b0;
        i_lsu_drive   = 1'b0;
        i_lsu_load    = 1'b0;
        i_lsu_pa      = '0;
        i_store_type  = '0;
        i_store_data  = '0;
        i_store_index = '0;
        repeat (3) @(posedge w_Selector2_fire_2);
        #1;
        rstn = 1'b1;
        reset_idle();
        load_miss_then_hit();
        store_bytes();
        plru_eviction();
        dirty_write_back();
        random_mix();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- vlog.f
hw/dcache_pkg.sv
hw/dcache_plru.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tests/dcache_assert.sv
tests/tb_dcache.sv
